/* Makefile */
# Verilator build and run for the beeb memory subsystem

VERILATOR ?= verilator
TOP       ?= beeb_mem_tb
FILELIST  ?= beeb_mem.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* beeb_mem.f */
design/beeb_mem_pkg.sv
design/slot_decode.sv
design/mem_execute.sv
design/read_result.sv
design/beeb_mem_top.sv
sim/beeb_mem_properties.sv
sim/beeb_mem_tb.sv

/* design/beeb_mem_pkg.sv */
// beeb memory subsystem definitions
`default_nettype none

package beeb_mem_pkg;

	// ======================================================================
	// address fields
	// ======================================================================

	// full-size bank offset, 16 KB banks
	localparam int DEFAULT_OFFSET_W = 14;

	// 16-slot window select
	localparam int SLOT_W = 4;

	// ram/rom select sits just above the slot field
	localparam int RAM_SEL_BIT = DEFAULT_OFFSET_W + SLOT_W;

	// ======================================================================
	// banks
	// ======================================================================

	// 4 banks for the b table, 10 for the master table
	localparam int NUM_ROM_BANKS = 14;

	// ram slots 0..12 have storage behind them
	localparam int NUM_RAM_BANKS = 13;

	// physical bank index
	localparam int BANK_W = 4;

	// decoded access, carried down the pipeline
	typedef enum logic [2:0] {
		ACC_ROM_READ      = 3'd0,
		ACC_ROM_WRITE     = 3'd1,
		ACC_RAM_READ      = 3'd2,
		ACC_RAM_WRITE     = 3'd3,
		ACC_UNMAPPED_READ = 3'd4,
		ACC_REJECT        = 3'd5
	} access_kind_t;

	// machine model, picks the rom table
	typedef enum logic {
		MODEL_B      = 1'b0,
		MODEL_MASTER = 1'b1
	} model_t;

	// apb capture state
	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_BUSY = 1'b1
	} apb_state_t;

endpackage

`default_nettype wire

/* design/beeb_mem_top.sv */
// beeb memory subsystem top
`default_nettype none
`timescale 1ns/1ps

module beeb_mem_top import beeb_mem_pkg::*; #(
	parameter int OFFSET_W = DEFAULT_OFFSET_W
) (
	input  wire logic                clk_sys,
	input  wire logic                rst,
	// apb slave
	input  wire logic                psel,
	input  wire logic                penable,
	input  wire logic                pwrite,
	input  wire logic [OFFSET_W+4:0] paddr,
	input  wire logic [7:0]          pwdata,
	// machine config
	input  wire model_t              model,
	input  wire logic                rom_load,
	// apb response
	output logic      [7:0]          prdata,
	output logic                     pready,
	output logic                     pslverr
);

	// decode to execute
	logic                req_valid;
	access_kind_t        req_kind;
	logic [BANK_W-1:0]   req_bank;
	logic [OFFSET_W-1:0] req_offset;
	logic [7:0]          req_wdata;

	// execute to result
	logic                exe_valid;
	access_kind_t        exe_kind;
	logic [7:0]          exe_rdata;

	// apb capture and slot mapping
	slot_decode #(
		.OFFSET_W (OFFSET_W)
	) u_slot_decode (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.model      (model),
		.rom_load   (rom_load),
		.pready     (pready),
		.req_valid  (req_valid),
		.req_kind   (req_kind),
		.req_bank   (req_bank),
		.req_offset (req_offset),
		.req_wdata  (req_wdata)
	);

	// rom and ram storage
	mem_execute #(
		.OFFSET_W (OFFSET_W)
	) u_mem_execute (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.req_valid  (req_valid),
		.req_kind   (req_kind),
		.req_bank   (req_bank),
		.req_offset (req_offset),
		.req_wdata  (req_wdata),
		.exe_valid  (exe_valid),
		.exe_kind   (exe_kind),
		.exe_rdata  (exe_rdata)
	);

	// registered apb response
	read_result u_read_result (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.exe_valid (exe_valid),
		.exe_kind  (exe_kind),
		.exe_rdata (exe_rdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr)
	);

endmodule

`default_nettype wire

/* design/mem_execute.sv */
// rom and ram storage
`default_nettype none
`timescale 1ns/1ps

module mem_execute import beeb_mem_pkg::*; #(
	parameter int OFFSET_W = DEFAULT_OFFSET_W
) (
	input  wire logic                clk_sys,
	input  wire logic                rst,
	input  wire logic                req_valid,
	input  wire access_kind_t        req_kind,
	input  wire logic [BANK_W-1:0]   req_bank,
	input  wire logic [OFFSET_W-1:0] req_offset,
	input  wire logic [7:0]          req_wdata,
	output logic                     exe_valid,
	output access_kind_t             exe_kind,
	output logic      [7:0]          exe_rdata
);

	localparam int BANK_BYTES = 2 ** OFFSET_W;
	localparam int ROM_DEPTH  = NUM_ROM_BANKS * BANK_BYTES;
	localparam int RAM_DEPTH  = NUM_RAM_BANKS * BANK_BYTES;

	// flat arrays, bank in the upper address bits
	logic [7:0] rom_mem [ROM_DEPTH];
	logic [7:0] ram_mem [RAM_DEPTH];

	logic [BANK_W+OFFSET_W-1:0] mem_addr;
	logic [7:0]                 rom_rd;
	logic [7:0]                 ram_rd;

	assign mem_addr = {req_bank, req_offset};

	// ======================================================================
	// rom
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		// kind already carries the rom_load check
		if (req_valid && req_kind == ACC_ROM_WRITE)
			rom_mem[mem_addr] <= req_wdata;
		rom_rd <= rom_mem[mem_addr];
	end

	// ======================================================================
	// ram
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (req_valid && req_kind == ACC_RAM_WRITE)
			ram_mem[mem_addr] <= req_wdata;
		ram_rd <= ram_mem[mem_addr];
	end

	// valid and kind one cycle behind the request
	always_ff @(posedge clk_sys) begin
		if (rst)
			exe_valid <= 1'b0;
		else
			exe_valid <= req_valid;
	end

	always_ff @(posedge clk_sys) begin
		if (req_valid)
			exe_kind <= req_kind;
	end

	// pick the array that was read
	assign exe_rdata = (exe_kind == ACC_RAM_READ) ? ram_rd : rom_rd;

endmodule

`default_nettype wire

/* design/read_result.sv */
// apb response register
`default_nettype none
`timescale 1ns/1ps

module read_result import beeb_mem_pkg::*; (
	input  wire logic         clk_sys,
	input  wire logic         rst,
	input  wire logic         exe_valid,
	input  wire access_kind_t exe_kind,
	input  wire logic [7:0]   exe_rdata,
	output logic      [7:0]   prdata,
	output logic              pready,
	output logic              pslverr
);

	logic data_kind;
	logic err_kind;

	// only real reads return data
	assign data_kind = (exe_kind == ACC_ROM_READ) || (exe_kind == ACC_RAM_READ);

	// unmapped writes and protected rom writes
	assign err_kind  = (exe_kind == ACC_REJECT);

	// ======================================================================
	// response
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			prdata  <= 8'h00;
			pready  <= 1'b0;
			pslverr <= 1'b0;
		end else begin
			// single-cycle pready pulse
			pready  <= exe_valid;
			pslverr <= exe_valid && err_kind;
			// zero outside the response cycle
			if (exe_valid && data_kind)
				prdata <= exe_rdata;
			else
				prdata <= 8'h00;
		end
	end

endmodule

`default_nettype wire

/* design/slot_decode.sv */
// apb capture and slot decode
`default_nettype none
`timescale 1ns/1ps

module slot_decode import beeb_mem_pkg::*; #(
	parameter int OFFSET_W = DEFAULT_OFFSET_W
) (
	input  wire logic                clk_sys,
	input  wire logic                rst,
	input  wire logic                psel,
	input  wire logic                penable,
	input  wire logic                pwrite,
	input  wire logic [OFFSET_W+4:0] paddr,
	input  wire logic [7:0]          pwdata,
	input  wire model_t              model,
	input  wire logic                rom_load,
	input  wire logic                pready,
	output logic                     req_valid,
	output access_kind_t             req_kind,
	output logic      [BANK_W-1:0]   req_bank,
	output logic      [OFFSET_W-1:0] req_offset,
	output logic      [7:0]          req_wdata
);

	// ram select moves down with a shorter offset field
	localparam int RAM_BIT = RAM_SEL_BIT - DEFAULT_OFFSET_W + OFFSET_W;

	apb_state_t        state;
	model_t            model_q;
	logic [SLOT_W-1:0] slot;
	logic              is_ram;
	logic              rom_hit;
	logic [BANK_W-1:0] rom_bank;
	logic              slot_hit;
	logic [BANK_W-1:0] bank_next;
	access_kind_t      kind_next;
	logic              start;

	assign slot   = paddr[OFFSET_W +: SLOT_W];
	assign is_ram = paddr[RAM_BIT];

	// first access-phase cycle of a new transfer
	assign start  = (state == ST_IDLE) && psel && penable;

	// model is latched only while held in reset
	always_ff @(posedge clk_sys) begin
		if (rst)
			model_q <= model;
	end

	// ======================================================================
	// rom tables
	// ======================================================================
	always_comb begin
		rom_hit  = 1'b1;
		rom_bank = '0;
		if (model_q == MODEL_MASTER) begin
			case (slot)
				4'd2:    rom_bank = 4'd4;
				4'd3:    rom_bank = 4'd5;
				4'd4:    rom_bank = 4'd6;
				4'd9:    rom_bank = 4'd7;
				4'd10:   rom_bank = 4'd8;
				4'd11:   rom_bank = 4'd9;
				4'd12:   rom_bank = 4'd10;
				4'd13:   rom_bank = 4'd11;
				4'd14:   rom_bank = 4'd12;
				4'd15:   rom_bank = 4'd13;
				default: rom_hit  = 1'b0;
			endcase
		end else begin
			// b model, os / filing system / sideways ram / basic
			case (slot)
				4'd4:    rom_bank = 4'd0;
				4'd8:    rom_bank = 4'd1;
				4'd14:   rom_bank = 4'd2;
				4'd15:   rom_bank = 4'd3;
				default: rom_hit  = 1'b0;
			endcase
		end
	end

	// classify the access
	always_comb begin
		if (is_ram) begin
			// ram bank is the slot, top three slots empty
			slot_hit  = int'(slot) < NUM_RAM_BANKS;
			bank_next = BANK_W'(slot);
		end else begin
			slot_hit  = rom_hit;
			bank_next = rom_bank;
		end
		if (!slot_hit)
			kind_next = pwrite ? ACC_REJECT : ACC_UNMAPPED_READ;
		else if (is_ram)
			kind_next = pwrite ? ACC_RAM_WRITE : ACC_RAM_READ;
		else if (!pwrite)
			kind_next = ACC_ROM_READ;
		else
			// rom is writable only during load
			kind_next = rom_load ? ACC_ROM_WRITE : ACC_REJECT;
	end

	// ======================================================================
	// capture fsm
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state     <= ST_IDLE;
			req_valid <= 1'b0;
		end else begin
			req_valid <= 1'b0;
			case (state)
				ST_IDLE: if (start) begin
					state     <= ST_BUSY;
					req_valid <= 1'b1;
				end
				// psel ignored here until the response is out
				ST_BUSY: if (pready)
					state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// request payload
	always_ff @(posedge clk_sys) begin
		if (start) begin
			req_kind   <= kind_next;
			req_bank   <= bank_next;
			req_offset <= paddr[OFFSET_W-1:0];
			req_wdata  <= pwdata;
		end
	end

endmodule

`default_nettype wire

/* sim/beeb_mem_properties.sv */
// apb response properties
`default_nettype none
`timescale 1ns/1ps

module beeb_mem_properties (
	input wire logic clk_sys,
	input wire logic rst,
	input wire logic psel,
	input wire logic penable,
	input wire logic pready,
	input wire logic pslverr
);

	logic access;

	// access phase of a transfer
	assign access = psel && penable;

	// ======================================================================
	// response timing
	// ======================================================================

	// pready is a single-cycle pulse
	assert property (@(posedge clk_sys) disable iff (rst) pready |=> !pready)
		else $error("pready held high for two cycles");

	// response in the fourth access-phase cycle
	assert property (@(posedge clk_sys) disable iff (rst)
		$rose(access) |-> !pready ##1 !pready ##1 !pready ##1 pready)
		else $error("pready not in the fourth access-phase cycle");

	// reset clears the response
	assert property (@(posedge clk_sys) rst |=> (!pready && !pslverr))
		else $error("pready or pslverr set after reset");

endmodule

`default_nettype wire

/* sim/beeb_mem_tb.sv */
// beeb memory subsystem testbench
`default_nettype none
`timescale 1ns/1ps

module beeb_mem_tb import beeb_mem_pkg::*; ();

	localparam int OFFSET_W    = 6;
	localparam int ADDR_W      = OFFSET_W + 5;
	localparam int MAX_ENTRIES = 64;

	logic              clk_sys = 1'b0;
	logic              rst;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [ADDR_W-1:0] paddr;
	logic [7:0]        pwdata;
	model_t            model;
	logic              rom_load;
	logic [7:0]        prdata;
	logic              pready;
	logic              pslverr;

	// stimulus table
	string             tbl_name     [MAX_ENTRIES];
	model_t            tbl_model    [MAX_ENTRIES];
	logic              tbl_load     [MAX_ENTRIES];
	logic              tbl_wr       [MAX_ENTRIES];
	logic [ADDR_W-1:0] tbl_addr     [MAX_ENTRIES];
	logic [7:0]        tbl_wdata    [MAX_ENTRIES];
	logic [7:0]        tbl_exp_data [MAX_ENTRIES];
	logic              tbl_exp_err  [MAX_ENTRIES];
	int                n_entries = 0;

	logic [7:0] ram_data [NUM_RAM_BANKS];
	integer     seed;
	int         errors = 0;
	int         checks = 0;
	int         cycles = 0;
	int         timeout_limit = 100;
	model_t     cur_model;

	beeb_mem_top #(
		.OFFSET_W (OFFSET_W)
	) u_beeb_mem_top (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.model    (model),
		.rom_load (rom_load),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr)
	);

	bind beeb_mem_top beeb_mem_properties u_beeb_mem_properties (
		.clk_sys (clk_sys),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.pready  (pready),
		.pslverr (pslverr)
	);

	// 10 ns clock
	always #5 clk_sys = ~clk_sys;

	// watchdog
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_limit) begin
			$display("timeout: no end of run after %0d cycles", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ======================================================================
	// helpers
	// ======================================================================

	// ram bit, then slot, then bank offset
	function automatic logic [ADDR_W-1:0] make_addr(input logic ram, input int slot,
		input int offset);
		make_addr = {ram, SLOT_W'(slot), OFFSET_W'(offset)};
	endfunction

	task automatic add_entry(input string name, input model_t m, input logic load,
		input logic wr, input logic [ADDR_W-1:0] addr, input logic [7:0] wdata,
		input logic [7:0] exp_data, input logic exp_err);
		tbl_name[n_entries]     = name;
		tbl_model[n_entries]    = m;
		tbl_load[n_entries]     = load;
		tbl_wr[n_entries]       = wr;
		tbl_addr[n_entries]     = addr;
		tbl_wdata[n_entries]    = wdata;
		tbl_exp_data[n_entries] = exp_data;
		tbl_exp_err[n_entries]  = exp_err;
		n_entries++;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
			errors++;
		end
	endtask

	// ======================================================================
	// table
	// ======================================================================
	task automatic build_table();
		int         b_slots [4] = '{4, 8, 14, 15};
		int         b_offs  [4] = '{1, 2, 3, 63};
		logic [7:0] b_vals  [4] = '{8'hA1, 8'hB2, 8'hC3, 8'hD4};
		int         s;
		for (s = 0; s < 4; s++)
			add_entry("rom_load_b", MODEL_B, 1'b1, 1'b1, make_addr(1'b0, b_slots[s], b_offs[s]),
				b_vals[s], 8'h00, 1'b0);
		for (s = 0; s < 4; s++)
			add_entry("rom_read_b", MODEL_B, 1'b0, 1'b0, make_addr(1'b0, b_slots[s], b_offs[s]),
				8'h00, b_vals[s], 1'b0);
		// slot 0 has no rom in the b table
		// offset 1 holds data in the mapped banks
		add_entry("unmapped_read_b", MODEL_B, 1'b0, 1'b0, make_addr(1'b0, 0, 1),
			8'h00, 8'h00, 1'b0);
		add_entry("unmapped_write_b", MODEL_B, 1'b1, 1'b1, make_addr(1'b0, 0, 1),
			8'h33, 8'h00, 1'b1);
		// write protect keeps the old byte
		add_entry("rom_protect_write", MODEL_B, 1'b0, 1'b1, make_addr(1'b0, 8, 2),
			8'h5A, 8'h00, 1'b1);
		add_entry("rom_protect_read", MODEL_B, 1'b0, 1'b0, make_addr(1'b0, 8, 2),
			8'h00, 8'hB2, 1'b0);
		// seeded ram contents
		for (s = 0; s < NUM_RAM_BANKS; s++)
			ram_data[s] = 8'($random(seed));
		for (s = 0; s < NUM_RAM_BANKS; s++)
			add_entry("ram_write", MODEL_B, 1'b0, 1'b1, make_addr(1'b1, s, s * 4 + 1),
				ram_data[s], 8'h00, 1'b0);
		for (s = 0; s < NUM_RAM_BANKS; s++)
			add_entry("ram_read", MODEL_B, 1'b0, 1'b0, make_addr(1'b1, s, s * 4 + 1),
				8'h00, ram_data[s], 1'b0);
		for (s = NUM_RAM_BANKS; s < 16; s++) begin
			add_entry("ram_empty_read", MODEL_B, 1'b0, 1'b0, make_addr(1'b1, s, 5),
				8'h00, 8'h00, 1'b0);
			add_entry("ram_empty_write", MODEL_B, 1'b0, 1'b1, make_addr(1'b1, s, 5),
				8'hFF, 8'h00, 1'b1);
		end
		// master slot 4 is bank 6
		add_entry("master_load", MODEL_MASTER, 1'b1, 1'b1, make_addr(1'b0, 4, 1),
			8'h6E, 8'h00, 1'b0);
		add_entry("master_read", MODEL_MASTER, 1'b0, 1'b0, make_addr(1'b0, 4, 1),
			8'h00, 8'h6E, 1'b0);
		add_entry("unmapped_read_master", MODEL_MASTER, 1'b0, 1'b0, make_addr(1'b0, 5, 1),
			8'h00, 8'h00, 1'b0);
		add_entry("unmapped_write_master", MODEL_MASTER, 1'b1, 1'b1, make_addr(1'b0, 5, 1),
			8'h44, 8'h00, 1'b1);
		// back to b with bank 0 untouched
		add_entry("b_after_master", MODEL_B, 1'b0, 1'b0, make_addr(1'b0, 4, 1),
			8'h00, 8'hA1, 1'b0);
		add_entry("master_after_b", MODEL_MASTER, 1'b0, 1'b0, make_addr(1'b0, 4, 1),
			8'h00, 8'h6E, 1'b0);
	endtask

	// ======================================================================
	// bus tasks
	// ======================================================================

	// model is taken while rst is high
	task automatic apply_reset(input model_t m);
		rst     = 1'b1;
		model   = m;
		psel    = 1'b0;
		penable = 1'b0;
		repeat (4) @(posedge clk_sys);
		#1;
		rst = 1'b0;
		check_value("reset pready", 32'd0, 32'(pready));
		check_value("reset pslverr", 32'd0, 32'(pslverr));
		check_value("reset prdata", 32'd0, 32'(prdata));
	endtask

	// one apb transfer started 1 ns after a rising edge
	task automatic run_entry(input int i);
		string name;
		int    n;
		logic  got;
		name     = $sformatf("%s[%0d]", tbl_name[i], i);
		paddr    = tbl_addr[i];
		pwrite   = tbl_wr[i];
		pwdata   = tbl_wdata[i];
		rom_load = tbl_load[i];
		psel     = 1'b1;
		penable  = 1'b0;
		@(posedge clk_sys);
		#1;
		penable = 1'b1;
		n       = 1;
		got     = 1'b0;
		while (!got && n < 8) begin
			@(posedge clk_sys);
			#1;
			n++;
			got = pready;
		end
		if (!got) begin
			$display("%s: DUT gave no pready within 8 access-phase cycles", name);
			errors++;
		end else begin
			check_value({name, " pready cycle"}, 32'd4, 32'(n));
			check_value({name, " prdata"}, 32'(tbl_exp_data[i]), 32'(prdata));
			check_value({name, " pslverr"}, 32'(tbl_exp_err[i]), 32'(pslverr));
		end
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		@(posedge clk_sys);
		#1;
	endtask

	// ======================================================================
	// main
	// ======================================================================
	initial begin
		seed     = 52440;
		rst      = 1'b1;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = 8'h00;
		rom_load = 1'b0;
		model    = MODEL_B;
		build_table();
		timeout_limit = 8 * n_entries + 100;
		cur_model     = tbl_model[0];
		apply_reset(cur_model);
		for (int i = 0; i < n_entries; i++) begin
			// model switch goes through reset
			if (tbl_model[i] != cur_model) begin
				cur_model = tbl_model[i];
				apply_reset(cur_model);
			end
			run_entry(i);
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire
